// File: include/ara_macros.svh
/* Vector coprocessor size parameters
   Lane count, element width, slots per lane and register count */

`ifndef ARA_MACROS_SVH
`define ARA_MACROS_SVH

////////////////////////////////////////////////////////////
// Datapath geometry
////////////////////////////////////////////////////////////

// Number of lanes, power of two
`define ARA_NR_LANES 4

// Element width in bits
`define ARA_ELEN 16

// Elements per lane in each vector register
`define ARA_SLOTS 4

// Vector registers in the register file
`define ARA_NR_VREGS 8

`endif

// File: logic/ara.sv
/* Vector coprocessor top level: dispatcher, sequencer,
   a row of lanes and the reduction unit */

`timescale 1ns/1ps
`include "ara_macros.svh"

module ara import ara_pkg::*; import rvv_pkg::*; #(
  parameter int unsigned NrLanes = `ARA_NR_LANES
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Host request
  input  logic  acc_req_valid_i,
  input  vop_e  acc_req_op_i,
  input  vreg_t acc_req_vd_i,
  input  vreg_t acc_req_vs1_i,
  input  vreg_t acc_req_vs2_i,
  input  elen_t acc_req_scalar_i,
  output logic  acc_req_ready_o,
  // Host response
  output logic  acc_resp_valid_o,
  output elen_t acc_resp_data_o,
  output logic  acc_resp_error_o
);

  // Dispatcher to sequencer and lanes
  logic  seq_start;
  logic  seq_done;
  vop_e  seq_op;
  vreg_t seq_vd;
  vreg_t seq_vs1;
  vreg_t seq_vs2;
  elen_t seq_scalar;
  // Sequencer broadcast
  logic  elem_valid;
  slot_t elem_slot;
  logic  acc_clear;
  logic  red_req;
  // Lanes to reduction
  elen_t [NrLanes-1:0] partial_sum;
  elen_t [NrLanes-1:0] elem0;
  logic  red_valid;
  elen_t red_result;

  ara_dispatcher i_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_op_i     (acc_req_op_i    ),
    .acc_req_vd_i     (acc_req_vd_i    ),
    .acc_req_vs1_i    (acc_req_vs1_i   ),
    .acc_req_vs2_i    (acc_req_vs2_i   ),
    .acc_req_scalar_i (acc_req_scalar_i),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_data_o  (acc_resp_data_o ),
    .acc_resp_error_o (acc_resp_error_o),
    .seq_start_o      (seq_start       ),
    .seq_op_o         (seq_op          ),
    .seq_vd_o         (seq_vd          ),
    .seq_vs1_o        (seq_vs1         ),
    .seq_vs2_o        (seq_vs2         ),
    .seq_scalar_o     (seq_scalar      ),
    .seq_done_i       (seq_done        ),
    .red_valid_i      (red_valid       ),
    .red_result_i     (red_result      )
  );

  ara_sequencer i_sequencer (
    .clk_i        (clk_i     ),
    .rst_n_i      (rst_n_i   ),
    .seq_start_i  (seq_start ),
    .seq_op_i     (seq_op    ),
    .seq_done_o   (seq_done  ),
    .elem_valid_o (elem_valid),
    .elem_slot_o  (elem_slot ),
    .acc_clear_o  (acc_clear ),
    .red_req_o    (red_req   )
  );

  ////////////////////////////////////////////////////////////
  // Lanes
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vlane #(
      .LaneId (lane_id_t'(l))
    ) i_vlane (
      .clk_i         (clk_i         ),
      .rst_n_i       (rst_n_i       ),
      .elem_valid_i  (elem_valid    ),
      .elem_slot_i   (elem_slot     ),
      .acc_clear_i   (acc_clear     ),
      .op_i          (seq_op        ),
      .vd_i          (seq_vd        ),
      .vs1_i         (seq_vs1       ),
      .vs2_i         (seq_vs2       ),
      .scalar_i      (seq_scalar    ),
      .partial_sum_o (partial_sum[l]),
      .elem0_o       (elem0[l]      )
    );
  end : gen_lanes

  // Scalar read takes element 0 from lane 0
  ara_reduction i_reduction (
    .clk_i         (clk_i      ),
    .rst_n_i       (rst_n_i    ),
    .red_req_i     (red_req    ),
    .red_op_i      (seq_op     ),
    .scalar_i      (seq_scalar ),
    .partial_sum_i (partial_sum),
    .lane0_elem0_i (elem0[0]   ),
    .red_valid_o   (red_valid  ),
    .red_result_o  (red_result )
  );

  ////////////////////////////////////////////////////////////
  // Elaboration checks
  ////////////////////////////////////////////////////////////

  if (NrLanes == 0)
    $error("ara needs at least one lane");

  if (NrLanes != 2**$clog2(NrLanes))
    $error("ara lane count must be a power of two");

  if (NrLanes != `ARA_NR_LANES)
    $error("ara lane count must match ARA_NR_LANES");

endmodule : ara

// File: logic/ara_dispatcher.sv
/* Dispatcher: takes host requests, checks opcodes, holds operands
   and returns scalar or error responses */

`timescale 1ns/1ps

module ara_dispatcher import rvv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Host request
  input  logic  acc_req_valid_i,
  input  vop_e  acc_req_op_i,
  input  vreg_t acc_req_vd_i,
  input  vreg_t acc_req_vs1_i,
  input  vreg_t acc_req_vs2_i,
  input  elen_t acc_req_scalar_i,
  output logic  acc_req_ready_o,
  // Host response
  output logic  acc_resp_valid_o,
  output elen_t acc_resp_data_o,
  output logic  acc_resp_error_o,
  // Sequencer
  output logic  seq_start_o,
  output vop_e  seq_op_o,
  output vreg_t seq_vd_o,
  output vreg_t seq_vs1_o,
  output vreg_t seq_vs2_o,
  output elen_t seq_scalar_o,
  input  logic  seq_done_i,
  // Reduction unit
  input  logic  red_valid_i,
  input  elen_t red_result_i
);

  logic  busy_q;
  logic  start_q;
  logic  err_q;
  logic  accept;
  logic  op_defined;
  vop_e  op_q;
  vreg_t vd_q;
  vreg_t vs1_q;
  vreg_t vs2_q;
  elen_t scalar_q;

  assign acc_req_ready_o = !busy_q;
  assign accept          = acc_req_valid_i && acc_req_ready_o;
  assign op_defined      = acc_req_op_i inside {VADD, VSUB, VAND, VXOR,
                                                VMV_VX, VID, VREDSUM, VMV_XS};

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  // Busy from acceptance until done or the error answer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q  <= 1'b0;
      start_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      start_q <= accept && op_defined;
      err_q   <= accept && !op_defined;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (err_q || seq_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Operand holding registers
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= acc_req_op_i;
      vd_q     <= acc_req_vd_i;
      vs1_q    <= acc_req_vs1_i;
      vs2_q    <= acc_req_vs2_i;
      scalar_q <= acc_req_scalar_i;
    end
  end

  assign seq_start_o  = start_q;
  assign seq_op_o     = op_q;
  assign seq_vd_o     = vd_q;
  assign seq_vs1_o    = vs1_q;
  assign seq_vs2_o    = vs2_q;
  assign seq_scalar_o = scalar_q;

  // Error answer carries zero data
  assign acc_resp_valid_o = err_q || red_valid_i;
  assign acc_resp_error_o = err_q;
  assign acc_resp_data_o  = err_q ? '0 : red_result_i;

  // Reduction results only arrive for an instruction in flight
  a_resp_when_busy : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o |-> busy_q
  );

endmodule : ara_dispatcher

// File: logic/ara_pkg.sv
/* Microarchitecture types: sequencer states, slot and lane indices */

`include "ara_macros.svh"

package ara_pkg;

  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,
    SEQ_RUN    = 2'd1,
    SEQ_REDUCE = 2'd2
  } seq_state_e;

  // Keep at least one bit for a single slot or lane
  localparam int unsigned SlotW = (`ARA_SLOTS > 1) ? $clog2(`ARA_SLOTS) : 1;
  localparam int unsigned LaneW = (`ARA_NR_LANES > 1) ? $clog2(`ARA_NR_LANES) : 1;

  typedef logic [SlotW-1:0] slot_t;
  typedef logic [LaneW-1:0] lane_id_t;

endpackage : ara_pkg

// File: logic/ara_reduction.sv
/* Reduction unit: sums the lane partials and the scalar,
   or returns element 0 for a scalar read */

`timescale 1ns/1ps
`include "ara_macros.svh"

module ara_reduction import rvv_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         red_req_i,
  input  vop_e                         red_op_i,
  input  elen_t                        scalar_i,
  input  elen_t [`ARA_NR_LANES-1:0]    partial_sum_i,
  input  elen_t                        lane0_elem0_i,
  output logic                         red_valid_o,
  output elen_t                        red_result_o
);

  elen_t sum;
  logic  valid_q;
  elen_t result_q;

  // Wraps modulo 2**ELEN
  always_comb begin
    sum = scalar_i;
    for (int l = 0; l < `ARA_NR_LANES; l++) begin
      sum = sum + partial_sum_i[l];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= red_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (red_req_i) begin
      result_q <= (red_op_i == VMV_XS) ? lane0_elem0_i : sum;
    end
  end

  assign red_valid_o  = valid_q;
  assign red_result_o = valid_q ? result_q : '0;

endmodule : ara_reduction

// File: logic/ara_sequencer.sv
/* Sequencer: steps the element slots of one instruction and
   requests a reduction cycle for scalar results */

`timescale 1ns/1ps
`include "ara_macros.svh"

module ara_sequencer import ara_pkg::*; import rvv_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Dispatcher
  input  logic  seq_start_i,
  input  vop_e  seq_op_i,
  output logic  seq_done_o,
  // Lanes and reduction unit
  output logic  elem_valid_o,
  output slot_t elem_slot_o,
  output logic  acc_clear_o,
  output logic  red_req_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  slot_t      slot_q;
  logic       done_q;
  logic       last_slot;
  logic       needs_red;

  assign last_slot = (slot_q == slot_t'(`ARA_SLOTS - 1));
  assign needs_red = seq_op_i inside {VREDSUM, VMV_XS};

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (seq_start_i) begin
          state_d = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (last_slot) begin
          state_d = needs_red ? SEQ_REDUCE : SEQ_IDLE;
        end
      end
      SEQ_REDUCE: state_d = SEQ_IDLE;
      default:    state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
      slot_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Done one cycle after the last strobe or the reduce cycle
      done_q  <= (state_q == SEQ_RUN && last_slot && !needs_red) ||
                 (state_q == SEQ_REDUCE);
      if (state_q == SEQ_RUN) begin
        slot_q <= last_slot ? '0 : slot_q + 1'b1;
      end else begin
        slot_q <= '0;
      end
    end
  end

  assign seq_done_o   = done_q;
  assign elem_valid_o = (state_q == SEQ_RUN);
  assign elem_slot_o  = slot_q;
  assign acc_clear_o  = seq_start_i && (state_q == SEQ_IDLE);
  assign red_req_o    = (state_q == SEQ_REDUCE);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Dispatcher only starts an idle sequencer
  a_start_idle : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    seq_start_i |-> state_q == SEQ_IDLE
  );

  // A strobe burst lasts exactly one slot per cycle
  a_strobe_len : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(elem_valid_o) |-> elem_valid_o [*`ARA_SLOTS] ##1 !elem_valid_o
  );

endmodule : ara_sequencer

// File: logic/rvv_pkg.sv
/* Vector ISA types: opcodes, elements and register indices */

`include "ara_macros.svh"

package rvv_pkg;

  // Supported vector opcodes, other codes are undefined
  typedef enum logic [3:0] {
    VADD    = 4'h0,
    VSUB    = 4'h1,
    VAND    = 4'h2,
    VXOR    = 4'h3,
    VMV_VX  = 4'h4,
    VID     = 4'h5,
    VREDSUM = 4'h6,
    VMV_XS  = 4'h7
  } vop_e;

  // One vector element
  typedef logic [`ARA_ELEN-1:0] elen_t;

  // Vector register index
  typedef logic [$clog2(`ARA_NR_VREGS)-1:0] vreg_t;

endpackage : rvv_pkg

// File: logic/vlane.sv
/* Vector lane: register file slice, element ALU and
   partial-sum accumulator for reductions */

`timescale 1ns/1ps
`include "ara_macros.svh"

module vlane import ara_pkg::*; import rvv_pkg::*; #(
  parameter lane_id_t LaneId = '0
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  // Sequencer broadcast
  input  logic  elem_valid_i,
  input  slot_t elem_slot_i,
  input  logic  acc_clear_i,
  input  vop_e  op_i,
  input  vreg_t vd_i,
  input  vreg_t vs1_i,
  input  vreg_t vs2_i,
  input  elen_t scalar_i,
  // Reduction unit
  output elen_t partial_sum_o,
  output elen_t elem0_o
);

  // Register file slice, one element per slot
  elen_t vrf_q [`ARA_NR_VREGS][`ARA_SLOTS];

  elen_t acc_q;
  elen_t op_a;
  elen_t op_b;
  elen_t result;
  logic  writes_vd;
  logic  vrf_we;

  assign op_a = vrf_q[vs1_i][elem_slot_i];
  assign op_b = vrf_q[vs2_i][elem_slot_i];

  ////////////////////////////////////////////////////////////
  // Element ALU
  ////////////////////////////////////////////////////////////

  always_comb begin
    result    = '0;
    writes_vd = 1'b1;
    case (op_i)
      VADD:   result = op_a + op_b;
      VSUB:   result = op_a - op_b;
      VAND:   result = op_a & op_b;
      VXOR:   result = op_a ^ op_b;
      VMV_VX: result = scalar_i;
      // Global index of this slot in this lane
      VID:    result = elen_t'(int'(elem_slot_i) * `ARA_NR_LANES + int'(LaneId));
      default: writes_vd = 1'b0;
    endcase
  end

  assign vrf_we = elem_valid_i && writes_vd;

  always_ff @(posedge clk_i) begin
    if (vrf_we) begin
      vrf_q[vd_i][elem_slot_i] <= result;
    end
  end

  // Partial sum of vs2 over this lane's slots
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (acc_clear_i) begin
      acc_q <= '0;
    end else if (elem_valid_i && op_i == VREDSUM) begin
      acc_q <= acc_q + op_b;
    end
  end

  assign partial_sum_o = acc_q;
  assign elem0_o       = vrf_q[vs2_i][0];

  // Consecutive writes step through the slots in order
  a_write_order : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    vrf_we && $past(elem_valid_i) |-> elem_slot_i == slot_t'($past(elem_slot_i) + 1'b1)
  );

endmodule : vlane

// File: run_sim.sh
#!/bin/sh
# Build and run the vector coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_ara -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_ara)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

// File: sim.f
+incdir+include
logic/rvv_pkg.sv
logic/ara_pkg.sv
logic/ara_dispatcher.sv
logic/ara_sequencer.sv
logic/vlane.sv
logic/ara_reduction.sv
logic/ara.sv
tests/tb_ara.sv

// File: tests/tb_ara.sv
/* Testbench for the vector coprocessor
   Register-file model, response assertions and a watchdog */

`timescale 1ns/1ps
`include "ara_macros.svh"

module tb_ara import rvv_pkg::*; ();

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int VLEN         = `ARA_NR_LANES * `ARA_SLOTS;
  localparam int NR_INSTR     = 26;
  localparam int WATCHDOG_NS  = RESET_CYCLES * CLK_PERIOD +
                                NR_INSTR * (`ARA_SLOTS + 4) * 40;

  logic  clk;
  logic  rst_n;
  logic  req_valid;
  vop_e  req_op;
  vreg_t req_vd;
  vreg_t req_vs1;
  vreg_t req_vs2;
  elen_t req_scalar;
  logic  req_ready;
  logic  resp_valid;
  elen_t resp_data;
  logic  resp_error;

  // Register file as the ISA rules define it
  elen_t mdl_vrf [`ARA_NR_VREGS][VLEN];

  // Expected responses in issue order
  elen_t exp_data_arr [NR_INSTR];
  logic  exp_err_arr  [NR_INSTR];
  int    push_count   = 0;
  int    resp_count   = 0;
  int    accept_count = 0;
  int    issued_count = 0;
  int    resp_errors  = 0;
  int    check_errors = 0;
  int    tests_passed = 0;
  int    tests_failed = 0;
  logic  exp_any;
  elen_t exp_data;
  logic  exp_err;

  // Keep valid up for one more cycle after the accepting edge
  logic  hold_after_accept = 1'b0;

  logic [31:0] lcg_state = 32'd44515;

  assign exp_any  = (resp_count < push_count);
  assign exp_data = exp_data_arr[resp_count];
  assign exp_err  = exp_err_arr[resp_count];

  ara i_ara (
    .clk_i            (clk       ),
    .rst_n_i          (rst_n     ),
    .acc_req_valid_i  (req_valid ),
    .acc_req_op_i     (req_op    ),
    .acc_req_vd_i     (req_vd    ),
    .acc_req_vs1_i    (req_vs1   ),
    .acc_req_vs2_i    (req_vs2   ),
    .acc_req_scalar_i (req_scalar),
    .acc_req_ready_o  (req_ready ),
    .acc_resp_valid_o (resp_valid),
    .acc_resp_data_o  (resp_data ),
    .acc_resp_error_o (resp_error)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // Outputs only change on edges, so edge counting is race free
  always @(posedge clk) begin
    if (resp_valid) begin
      resp_count <= resp_count + 1;
    end
    if (req_valid && req_ready) begin
      accept_count <= accept_count + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////

  a_resp_expected : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> exp_any)
  else begin
    $display("At %0t a response arrived that no request asked for", $time);
    resp_errors = resp_errors + 1;
  end

  a_resp_error : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && exp_any |-> resp_error == exp_err)
  else begin
    $display("mismatch at %0t: acc_resp_error_o expected %b, actual %b",
             $time, $sampled(exp_err), $sampled(resp_error));
    resp_errors = resp_errors + 1;
  end

  // Data only matters for a good response
  a_resp_data : assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && exp_any && !exp_err |-> resp_data == exp_data)
  else begin
    $display("mismatch at %0t: acc_resp_data_o expected %h, actual %h",
             $time, $sampled(exp_data), $sampled(resp_data));
    resp_errors = resp_errors + 1;
  end

  ////////////////////////////////////////////////////////////
  // Model and drivers
  ////////////////////////////////////////////////////////////

  function automatic elen_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return elen_t'(lcg_state >> 16);
  endfunction

  function automatic void update_model(input vop_e op, input vreg_t vd, input vreg_t vs1,
                                       input vreg_t vs2, input elen_t scalar);
    for (int e = 0; e < VLEN; e++) begin
      case (op)
        VADD:    mdl_vrf[vd][e] = mdl_vrf[vs1][e] + mdl_vrf[vs2][e];
        VSUB:    mdl_vrf[vd][e] = mdl_vrf[vs1][e] - mdl_vrf[vs2][e];
        VAND:    mdl_vrf[vd][e] = mdl_vrf[vs1][e] & mdl_vrf[vs2][e];
        VXOR:    mdl_vrf[vd][e] = mdl_vrf[vs1][e] ^ mdl_vrf[vs2][e];
        VMV_VX:  mdl_vrf[vd][e] = scalar;
        VID:     mdl_vrf[vd][e] = elen_t'(e);
        default: mdl_vrf[vd][e] = mdl_vrf[vd][e];
      endcase
    end
  endfunction

  task automatic expect_resp(input elen_t data, input logic err);
    exp_data_arr[push_count] = data;
    exp_err_arr[push_count]  = err;
    push_count = push_count + 1;
  endtask

  // Called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic issue(input vop_e op, input vreg_t vd, input vreg_t vs1,
                       input vreg_t vs2, input elen_t scalar);
    elen_t sum;
    logic  taken;
    sum = scalar;
    for (int e = 0; e < VLEN; e++) begin
      sum = sum + mdl_vrf[vs2][e];
    end
    case (op)
      VREDSUM: expect_resp(sum, 1'b0);
      VMV_XS:  expect_resp(mdl_vrf[vs2][0], 1'b0);
      VADD, VSUB, VAND, VXOR, VMV_VX, VID: update_model(op, vd, vs1, vs2, scalar);
      default: expect_resp('0, 1'b1);
    endcase
    req_valid  = 1'b1;
    req_op     = op;
    req_vd     = vd;
    req_vs1    = vs1;
    req_vs2    = vs2;
    req_scalar = scalar;
    taken      = 1'b0;
    while (!taken) begin
      taken = req_ready;
      @(posedge clk);
      #2;
    end
    // Ready must be low here, so the request is not taken twice
    if (hold_after_accept) begin
      @(posedge clk);
      #2;
    end
    req_valid    = 1'b0;
    issued_count = issued_count + 1;
  endtask

  task automatic wait_idle();
    while (!req_ready) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic run(input vop_e op, input vreg_t vd, input vreg_t vs1,
                     input vreg_t vs2, input elen_t scalar);
    issue(op, vd, vs1, vs2, scalar);
    wait_idle();
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (resp_errors + check_errors == errs_before) begin
      tests_passed = tests_passed + 1;
      $display("Test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %s: %0d errors", name, resp_errors + check_errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    vop_e ew_ops [4];
    int   errs;
    ew_ops     = '{VADD, VSUB, VAND, VXOR};
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_op     = VADD;
    req_vd     = '0;
    req_vs1    = '0;
    req_vs2    = '0;
    req_scalar = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    errs = resp_errors + check_errors;
    @(posedge clk);
    #2;
    assert (req_ready && !resp_valid)
    else begin
      $display("After reset the unit is not idle: ready %b, response valid %b",
               req_ready, resp_valid);
      check_errors = check_errors + 1;
    end
    report_test("reset state", errs);

    errs = resp_errors + check_errors;
    run(VMV_VX, vreg_t'(1), '0, '0, lcg_next());
    run(VMV_XS, '0, '0, vreg_t'(1), '0);
    run(VID, vreg_t'(2), '0, '0, '0);
    run(VMV_XS, '0, '0, vreg_t'(2), '0);
    report_test("broadcast and index", errs);

    // v1 holds a broadcast value, v2 the element index
    errs = resp_errors + check_errors;
    foreach (ew_ops[i]) begin
      run(ew_ops[i], vreg_t'(3), vreg_t'(1), vreg_t'(2), '0);
      run(VREDSUM, '0, '0, vreg_t'(3), lcg_next());
    end
    report_test("element-wise ops", errs);

    errs = resp_errors + check_errors;
    repeat (4) begin
      run(VMV_VX, vreg_t'(4), '0, '0, lcg_next());
      run(VREDSUM, '0, '0, vreg_t'(4), lcg_next());
    end
    report_test("sum reduction", errs);

    // Undefined op aimed at v3, which must keep its contents
    errs = resp_errors + check_errors;
    run(vop_e'(4'hF), vreg_t'(3), vreg_t'(2), vreg_t'(1), lcg_next());
    run(VMV_XS, '0, '0, vreg_t'(1), '0);
    run(VREDSUM, '0, '0, vreg_t'(3), '0);
    report_test("undefined opcode", errs);

    // Later requests wait at the interface while the unit is busy
    errs = resp_errors + check_errors;
    hold_after_accept = 1'b1;
    issue(VMV_VX, vreg_t'(5), '0, '0, lcg_next());
    issue(VMV_XS, '0, '0, vreg_t'(5), '0);
    issue(VREDSUM, '0, '0, vreg_t'(5), lcg_next());
    hold_after_accept = 1'b0;
    wait_idle();
    assert (accept_count == issued_count)
    else begin
      $display("mismatch at %0t: accepted requests expected %0d, actual %0d",
               $time, issued_count, accept_count);
      check_errors = check_errors + 1;
    end
    assert (resp_count == push_count)
    else begin
      $display("mismatch at %0t: acc_resp_valid_o pulses expected %0d, actual %0d",
               $time, push_count, resp_count);
      check_errors = check_errors + 1;
    end
    report_test("held requests", errs);

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && resp_errors + check_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_ara
